// File: source/hci_mem_pkg.sv
`default_nettype none

package hci_mem_pkg;

  // bus geometry shared by the demux, the banks and the top level.
  localparam int unsigned ADDR_W = 32; // byte address width.
  localparam int unsigned DATA_W = 32; // data word width.
  localparam int unsigned BE_W   = DATA_W / 8; // one enable per byte lane.

  // Response timing of a bank.
  // A request granted at one edge gets its r_valid this many cycles later.
  localparam int unsigned DEFAULT_LATENCY = 2;

  // number of address windows, and therefore banks, in the default build.
  localparam int unsigned DEFAULT_NB_REGION = 2;

endpackage

`default_nettype wire

// File: source/mem_bus_intf.sv
`timescale 1ns/10ps
`default_nettype none

// One link of the core memory bus.
// The request side is qualified by req and gnt, the response side by r_valid.
interface mem_bus_intf #(
  parameter int unsigned ADDR_W = hci_mem_pkg::ADDR_W,
  parameter int unsigned DATA_W = hci_mem_pkg::DATA_W
);

  // request channel, driven by the initiator.
  logic                  req;
  logic [ADDR_W-1:0]     add;
  logic                  wen;   // high for a read, low for a write.
  logic [DATA_W-1:0]     data;
  logic [DATA_W/8-1:0]   be;

  // grant and response channel, driven by the target.
  logic                  gnt;
  logic                  r_valid;
  logic [DATA_W-1:0]     r_data;
  logic                  r_opc; // set on an access beyond the bank depth.

  modport initiator (
    output req, add, wen, data, be,
    input  gnt, r_valid, r_data, r_opc
  );

  modport target (
    input  req, add, wen, data, be,
    output gnt, r_valid, r_data, r_opc
  );

endinterface

`default_nettype wire

// File: source/sram_bank.sv
`timescale 1ns/10ps
`default_nettype none

module sram_bank #(
  parameter int unsigned BANK_WORDS = 256,
  parameter int unsigned LATENCY    = hci_mem_pkg::DEFAULT_LATENCY,
  parameter int unsigned ADDR_W     = hci_mem_pkg::ADDR_W,
  parameter int unsigned DATA_W     = hci_mem_pkg::DATA_W
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  mem_bus_intf.target bus_i
);

  localparam int unsigned OFF_W = $clog2(DATA_W / 8); // byte offset bits within a word.
  localparam int unsigned IDX_W = $clog2(BANK_WORDS);
  localparam int unsigned CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic [DATA_W-1:0] mem_q [BANK_WORDS];

  logic [ADDR_W-OFF_W-1:0] word_idx;
  logic                    in_range;
  logic                    grant;

  logic              pending_q;  // one response in flight.
  logic [CNT_W-1:0]  cnt_q;      // cycles left until r_valid.
  logic              opc_q;
  logic [DATA_W-1:0] rdata_q;

  assign word_idx = bus_i.add[ADDR_W-1:OFF_W];
  assign in_range = (word_idx < BANK_WORDS);

  assign bus_i.gnt = bus_i.req & ~pending_q;
  assign grant     = bus_i.req & bus_i.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
      opc_q     <= 1'b0;
    end else if (clear_i) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
      opc_q     <= 1'b0;
    end else if (grant) begin
      pending_q <= 1'b1;
      cnt_q     <= CNT_W'(LATENCY - 1);
      opc_q     <= ~in_range;
    end else if (pending_q) begin
      if (cnt_q == '0) begin
        pending_q <= 1'b0; // the r_valid cycle is ending.
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage and read capture.
  always_ff @(posedge clk_i) begin
    if (grant && in_range && !bus_i.wen) begin
      for (int unsigned b = 0; b < DATA_W / 8; b++) begin
        if (bus_i.be[b]) begin
          mem_q[word_idx[IDX_W-1:0]][8*b +: 8] <= bus_i.data[8*b +: 8];
        end
      end
    end
    if (grant) begin
      rdata_q <= (in_range && bus_i.wen) ? mem_q[word_idx[IDX_W-1:0]] : '0;
    end
  end

  assign bus_i.r_valid = pending_q & (cnt_q == '0);
  assign bus_i.r_data  = bus_i.r_valid ? rdata_q : '0;
  assign bus_i.r_opc   = bus_i.r_valid & opc_q;

  // each response answers the grant taken exactly LATENCY cycles before.
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    bus_i.r_valid |-> pending_q && $past(grant, LATENCY))
    else $error("sram_bank: r_valid without a matching grant %0d cycles earlier", LATENCY);

endmodule

`default_nettype wire

// File: source/memmap_demux.sv
`timescale 1ns/10ps
`default_nettype none

module memmap_demux #(
  parameter int unsigned NB_REGION = hci_mem_pkg::DEFAULT_NB_REGION,
  parameter int unsigned ADDR_W    = hci_mem_pkg::ADDR_W,
  parameter int unsigned DATA_W    = hci_mem_pkg::DATA_W
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic [NB_REGION-1:0][ADDR_W-1:0] region_start_i,
  input  logic [NB_REGION-1:0][ADDR_W-1:0] region_end_i,
  mem_bus_intf.target                      target_i,
  mem_bus_intf.initiator                   initiator_o [NB_REGION]
);

  localparam int unsigned IDX_W = (NB_REGION > 1) ? $clog2(NB_REGION) : 1;

  typedef enum logic {
    IDLE,
    RESPONSE
  } state_e;

  state_e state_q, state_d;

  logic [IDX_W-1:0]  region_d;   // decoded window of the current address.
  logic [IDX_W-1:0]  region_q;   // window of the last granted request.
  logic              hit;        // address lies in at least one window.
  logic              region_sample;

  logic [NB_REGION-1:0]              bank_gnt;
  logic [NB_REGION-1:0]              bank_r_valid;
  logic [NB_REGION-1:0][DATA_W-1:0]  bank_r_data;
  logic [NB_REGION-1:0]              bank_r_opc;

  logic              sel_r_valid; // response strobe of the recorded bank.

  // Window decode.
  // Later indices overwrite earlier ones, so the highest matching region wins.
  always_comb begin
    hit      = 1'b0;
    region_d = '0;
    for (int unsigned i = 0; i < NB_REGION; i++) begin
      if ((target_i.add >= region_start_i[i]) && (target_i.add < region_end_i[i])) begin
        hit      = 1'b1;
        region_d = IDX_W'(i);
      end
    end
  end

  for (genvar ii = 0; ii < NB_REGION; ii++) begin : gen_route
    assign initiator_o[ii].req  = target_i.req & hit & (region_d == IDX_W'(ii));
    assign initiator_o[ii].add  = target_i.add - region_start_i[ii]; // rebase to window start.
    assign initiator_o[ii].wen  = target_i.wen;
    assign initiator_o[ii].data = target_i.data;
    assign initiator_o[ii].be   = target_i.be;

    assign bank_gnt[ii]     = initiator_o[ii].gnt;
    assign bank_r_valid[ii] = initiator_o[ii].r_valid;
    assign bank_r_data[ii]  = initiator_o[ii].r_data;
    assign bank_r_opc[ii]   = initiator_o[ii].r_opc;

    // only the bank that took the last grant may answer.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_r_valid[ii] |-> (state_q == RESPONSE) && (region_q == IDX_W'(ii)))
      else $error("memmap_demux: r_valid from bank %0d which holds no request", ii);
  end

  // the grant follows the current address combinationally.
  assign target_i.gnt = bank_gnt[region_d];

  assign sel_r_valid = bank_r_valid[region_q];

  always_comb begin
    state_d       = state_q;
    region_sample = 1'b0;
    if (target_i.req && target_i.gnt) begin
      state_d       = RESPONSE; // a new grant always retargets the response path.
      region_sample = 1'b1;
    end else if ((state_q == RESPONSE) && sel_r_valid) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      region_q <= '0;
    end else if (clear_i) begin
      state_q  <= IDLE;
      region_q <= '0;
    end else begin
      state_q <= state_d;
      if (region_sample) begin
        region_q <= region_d;
      end
    end
  end

  // Response steering.
  assign target_i.r_valid = (state_q == RESPONSE) ? sel_r_valid : 1'b0;
  assign target_i.r_data  = (state_q == RESPONSE) ? bank_r_data[region_q] : '0;
  assign target_i.r_opc   = (state_q == RESPONSE) ? bank_r_opc[region_q] : 1'b0;

  // an unmapped address must never be granted by any bank.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    target_i.gnt |-> hit)
    else $error("memmap_demux: grant seen for an unmapped address");

  // while a response is outstanding the requester stays on the same region.
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (state_q == RESPONSE) && !sel_r_valid && target_i.req && hit |-> region_d == region_q)
    else $error("memmap_demux: request to region %0d while region %0d is busy",
                region_d, region_q);

endmodule

`default_nettype wire

// File: source/region_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module region_bus_top #(
  parameter int unsigned NB_REGION  = hci_mem_pkg::DEFAULT_NB_REGION,
  parameter int unsigned BANK_WORDS = 256,
  parameter int unsigned LATENCY    = hci_mem_pkg::DEFAULT_LATENCY,
  parameter int unsigned ADDR_W     = hci_mem_pkg::ADDR_W,
  parameter int unsigned DATA_W     = hci_mem_pkg::DATA_W
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic [NB_REGION-1:0][ADDR_W-1:0] region_start_i,
  input  logic [NB_REGION-1:0][ADDR_W-1:0] region_end_i,

  input  logic                             req_i,
  input  logic [ADDR_W-1:0]                add_i,
  input  logic                             wen_i,
  input  logic [DATA_W-1:0]                data_i,
  input  logic [DATA_W/8-1:0]              be_i,

  output logic                             gnt_o,
  output logic                             r_valid_o,
  output logic [DATA_W-1:0]                r_data_o,
  output logic                             r_opc_o
);

  // requester side link, fed from the plain ports.
  mem_bus_intf #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) host_bus ();

  // one link per bank.
  mem_bus_intf #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) bank_bus [NB_REGION] ();

  assign host_bus.req  = req_i;
  assign host_bus.add  = add_i;
  assign host_bus.wen  = wen_i;
  assign host_bus.data = data_i;
  assign host_bus.be   = be_i;

  assign gnt_o     = host_bus.gnt;
  assign r_valid_o = host_bus.r_valid;
  assign r_data_o  = host_bus.r_data;
  assign r_opc_o   = host_bus.r_opc;

  memmap_demux #(
    .NB_REGION (NB_REGION),
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W)
  ) u_demux (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .region_start_i (region_start_i),
    .region_end_i   (region_end_i),
    .target_i       (host_bus),
    .initiator_o    (bank_bus)
  );

  for (genvar gi = 0; gi < NB_REGION; gi++) begin : gen_bank
    sram_bank #(
      .BANK_WORDS (BANK_WORDS),
      .LATENCY    (LATENCY),
      .ADDR_W     (ADDR_W),
      .DATA_W     (DATA_W)
    ) u_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .clear_i (clear_i),
      .bus_i   (bank_bus[gi])
    );
  end

endmodule

`default_nettype wire

// File: verification/tb_region_bus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_region_bus;

  localparam int unsigned NB_REGION  = 2;
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned LATENCY    = 2;
  localparam int unsigned ADDR_W     = hci_mem_pkg::ADDR_W;
  localparam int unsigned DATA_W     = hci_mem_pkg::DATA_W;
  localparam int unsigned BE_W       = hci_mem_pkg::BE_W;
  localparam int unsigned WAIT_LIMIT = 50;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              opc;
    logic [31:0]       due;  // cycle count at which r_valid is sampled.
  } resp_t;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             clear_i;
  logic [NB_REGION-1:0][ADDR_W-1:0] region_start_i;
  logic [NB_REGION-1:0][ADDR_W-1:0] region_end_i;
  logic                             req_i;
  logic [ADDR_W-1:0]                add_i;
  logic                             wen_i;
  logic [DATA_W-1:0]                data_i;
  logic [BE_W-1:0]                  be_i;
  logic                             gnt_o;
  logic                             r_valid_o;
  logic [DATA_W-1:0]                r_data_o;
  logic                             r_opc_o;

  logic [DATA_W-1:0] ref_mem [NB_REGION][BANK_WORDS]; // reference image of each bank.
  resp_t             exp_q [$];
  resp_t             exp_head;
  logic              resp_pending;
  logic              unmapped_active;
  logic [31:0]       cycle_cnt;
  logic [31:0]       rng_state;
  logic [31:0]       rnd;
  int unsigned       pick_region;
  int unsigned       pick_word;
  string             test_name;
  int unsigned       value_errors;
  int unsigned       protocol_errors;
  int unsigned       timeout_errors;

  region_bus_top #(
    .NB_REGION  (NB_REGION),
    .BANK_WORDS (BANK_WORDS),
    .LATENCY    (LATENCY)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .region_start_i (region_start_i),
    .region_end_i   (region_end_i),
    .req_i          (req_i),
    .add_i          (add_i),
    .wen_i          (wen_i),
    .data_i         (data_i),
    .be_i           (be_i),
    .gnt_o          (gnt_o),
    .r_valid_o      (r_valid_o),
    .r_data_o       (r_data_o),
    .r_opc_o        (r_opc_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // the highest index whose window holds the address owns it.
  function automatic int decode_region(input logic [ADDR_W-1:0] addr);
    for (int i = NB_REGION - 1; i >= 0; i--) begin
      if ((addr >= region_start_i[i]) && (addr < region_end_i[i])) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Updates the reference image for a granted access and returns its expected response.
  function automatic resp_t apply_to_model(input logic [ADDR_W-1:0] addr, input logic rd,
                                           input logic [DATA_W-1:0] wdata,
                                           input logic [BE_W-1:0] be);
    resp_t             resp;
    int                region;
    logic [ADDR_W-1:0] word;
    region    = decode_region(addr);
    word      = (addr - region_start_i[region]) >> 2; // rebased byte offset to word.
    resp.data = '0;
    resp.opc  = (word >= BANK_WORDS);
    resp.due  = cycle_cnt + LATENCY;
    if (!resp.opc && rd) begin
      resp.data = ref_mem[region][word];
    end else if (!resp.opc) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) begin
          ref_mem[region][word][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
    return resp;
  endfunction

  function automatic void refresh_expect();
    if (exp_q.size() != 0) begin
      resp_pending = 1'b1;
      exp_head     = exp_q[0];
    end else begin
      resp_pending = 1'b0;
      exp_head     = '0;
    end
  endfunction

  task automatic wait_response();
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (!r_valid_o && (waited < WAIT_LIMIT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (!r_valid_o) begin
      timeout_errors++;
      $display("%s: no r_valid arrived within %0d cycles", test_name, WAIT_LIMIT);
    end
    @(posedge clk_i);
    #0.5;
    void'(exp_q.pop_front());
    refresh_expect();
  endtask

  // One complete bus access. Starts and ends 0.5 ns after a rising edge.
  task automatic do_access(input logic [ADDR_W-1:0] addr, input logic rd,
                           input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
    int unsigned waited;
    req_i  = 1'b1;
    add_i  = addr;
    wen_i  = rd;
    data_i = wdata;
    be_i   = be;
    waited = 0;
    @(negedge clk_i);
    while (!gnt_o && (waited < WAIT_LIMIT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (!gnt_o) begin
      timeout_errors++;
      $display("%s: address %h was not granted within %0d cycles", test_name, addr, WAIT_LIMIT);
    end else begin
      exp_q.push_back(apply_to_model(addr, rd, wdata, be)); // transfer happens at the next edge.
      refresh_expect();
    end
    @(posedge clk_i);
    #0.5;
    req_i = 1'b0;
    if (exp_q.size() != 0) begin
      wait_response();
    end
  endtask

  task automatic check_unmapped(input logic [ADDR_W-1:0] addr);
    req_i           = 1'b1;
    add_i           = addr;
    wen_i           = 1'b1;
    data_i          = '0;
    be_i            = '1;
    unmapped_active = 1'b1;
    repeat (20) @(posedge clk_i);
    #0.5;
    req_i           = 1'b0;
    unmapped_active = 1'b0;
  endtask

  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid_o |-> resp_pending)
    else begin
      protocol_errors++;
      $display("%s: r_valid seen with no request in flight", test_name);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && resp_pending) |-> (cycle_cnt == exp_head.due))
    else begin
      value_errors++;
      $display("ERROR %s: r_valid cycle expected %0d actual %0d", test_name,
               exp_head.due, $sampled(cycle_cnt));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_pending && (cycle_cnt == exp_head.due)) |-> r_valid_o)
    else begin
      protocol_errors++;
      $display("%s: r_valid missing at cycle %0d", test_name, $sampled(cycle_cnt));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && resp_pending) |-> (r_data_o == exp_head.data))
    else begin
      value_errors++;
      $display("ERROR %s: r_data expected %h actual %h", test_name,
               exp_head.data, $sampled(r_data_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && resp_pending) |-> (r_opc_o == exp_head.opc))
    else begin
      value_errors++;
      $display("ERROR %s: r_opc expected %0b actual %0b", test_name,
               exp_head.opc, $sampled(r_opc_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) unmapped_active |-> !gnt_o)
    else begin
      protocol_errors++;
      $display("%s: an address outside every window was granted", test_name);
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(clear_i) |-> (!gnt_o && !r_valid_o))
    else begin
      protocol_errors++;
      $display("%s: gnt or r_valid high in the cycle after clear", test_name);
    end

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    clear_i           = 1'b0;
    region_start_i[0] = 32'h0000_1000;
    region_end_i[0]   = 32'h0000_1100;
    region_start_i[1] = 32'h0000_2000;
    region_end_i[1]   = 32'h0000_2200; // wider than the bank behind it.
    req_i             = 1'b0;
    add_i             = '0;
    wen_i             = 1'b1;
    data_i            = '0;
    be_i              = '0;
    unmapped_active   = 1'b0;
    resp_pending      = 1'b0;
    exp_head          = '0;
    cycle_cnt         = '0;
    rng_state         = 32'd49297;
    value_errors      = 0;
    protocol_errors   = 0;
    timeout_errors    = 0;
    test_name         = "reset";
    repeat (2) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #0.5;

    test_name = "fill"; // every word gets a known value first.
    for (int r = 0; r < NB_REGION; r++) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        do_access(region_start_i[r] + w * 4, 1'b0, next_rand(), '1);
      end
    end

    test_name = "random";
    for (int n = 0; n < 80; n++) begin
      rnd         = next_rand();
      pick_region = rnd[31];
      pick_word   = rnd[23:16] % ((pick_region == 0) ? 64 : 128);
      rnd         = next_rand();
      do_access(region_start_i[pick_region] + pick_word * 4, rnd[30], next_rand(), rnd[27:24]);
    end

    test_name = "readback";
    for (int r = 0; r < NB_REGION; r++) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        do_access(region_start_i[r] + w * 4, 1'b1, '0, '0);
      end
    end

    test_name = "out_of_depth";
    do_access(32'h0000_2000 + BANK_WORDS * 4, 1'b0, 32'hdead_beef, '1); // word 0 alias.
    do_access(32'h0000_2000 + BANK_WORDS * 4 + 8, 1'b1, '0, '0);
    do_access(32'h0000_2000, 1'b1, '0, '0);

    test_name = "unmapped";
    check_unmapped(32'h0000_3000);
    check_unmapped(32'h0000_1100); // end address is exclusive.

    test_name         = "overlap";
    region_start_i[1] = 32'h0000_1080;
    region_end_i[1]   = 32'h0000_1280;
    do_access(32'h0000_10c0, 1'b0, 32'ha5a5_0f0f, '1);
    region_start_i[1] = 32'h0000_2000;
    region_end_i[1]   = 32'h0000_2200;
    do_access(32'h0000_2040, 1'b1, '0, '0);
    do_access(32'h0000_10c0, 1'b1, '0, '0);

    test_name = "clear";
    req_i     = 1'b1; // this read is dropped by the clear before its response.
    add_i     = 32'h0000_1010;
    wen_i     = 1'b1;
    @(negedge clk_i);
    if (!gnt_o) begin
      protocol_errors++;
      $display("%s: the read ahead of the clear was not granted", test_name);
    end
    @(posedge clk_i);
    #0.5;
    req_i   = 1'b0;
    clear_i = 1'b1;
    @(posedge clk_i);
    #0.5;
    clear_i = 1'b0;
    repeat (LATENCY + 1) @(posedge clk_i);
    #0.5;
    do_access(32'h0000_1010, 1'b0, 32'h1234_5678, 4'b0101);
    do_access(32'h0000_1010, 1'b1, '0, '0);
    do_access(32'h0000_2010, 1'b1, '0, '0);

    repeat (4) @(posedge clk_i);
    $display("summary: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errors, protocol_errors, timeout_errors);
    if ((value_errors + protocol_errors + timeout_errors) == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/hci_mem_pkg.sv
source/mem_bus_intf.sv
source/sram_bank.sv
source/memmap_demux.sv
source/region_bus_top.sv
verification/tb_region_bus.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure.

cd "$(dirname "$0")" || exit 1

TOP=tb_region_bus
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --assert -Wno-fatal -f src.f --top-module "$TOP" \
  -Mdir obj_dir -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  echo "result: FAIL"
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "result: FAIL, the run ended without a verdict"
  exit 1
fi

echo "result: PASS"
exit 0
